//--- Bender.yml
package:
  name: sobel

sources:
  - verilog/sobel_pkg.sv
  - verilog/line_buffer.sv
  - verilog/window_datapath.sv
  - verilog/window_ctrl.sv
  - verilog/gradient_x.sv
  - verilog/gradient_y.sv
  - verilog/edge_combine.sv
  - verilog/apb_regs.sv
  - verilog/sobel_top.sv
  - target: test
    files:
      - test/tb_sobel.sv

//--- files.f
verilog/sobel_pkg.sv
verilog/line_buffer.sv
verilog/window_datapath.sv
verilog/window_ctrl.sv
verilog/gradient_x.sv
verilog/gradient_y.sv
verilog/edge_combine.sv
verilog/apb_regs.sv
verilog/sobel_top.sv
test/tb_sobel.sv

//--- test/tb_sobel.sv
`timescale 1ns/10ps

module tb_sobel;
  import sobel_pkg::*;

  localparam int ROWS            = 5;
  localparam int COLS            = 5;
  localparam int NPIX            = ROWS * COLS;
  localparam int NUM_FRAMES      = 6;
  localparam int STEP_CYCLES     = (ROWS + 1) * (COLS + 1) * 4;
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * STEP_CYCLES + 200;

  logic    clk;
  logic    rst_n;
  logic    i_pix_valid;
  pix_t    i_pix;
  logic    o_pix_ready;
  logic    o_res_valid;
  result_t o_res;
  logic    i_psel;
  logic    i_penable;
  logic    i_pwrite;
  addr_t   i_paddr;
  data_t   i_pwdata;
  data_t   o_prdata;
  logic    o_pready;

  pix_t  img [NPIX];
  int    got_mag [NPIX];
  int    exp_mag_q [$];
  int    exp_edge_q [$];
  int    exp_m;
  int    exp_e;
  int    res_idx;
  int    res_total;
  int    frames_sent;
  int    frames_exp;
  int    model_edges;
  int    thresh_now;
  data_t rd_data;

  sobel_top #(
    .ROWS (ROWS),
    .COLS (COLS)
  ) sobel_top_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_pix_valid (i_pix_valid),
    .i_pix       (i_pix),
    .o_pix_ready (o_pix_ready),
    .o_res_valid (o_res_valid),
    .o_res       (o_res),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .o_pready    (o_pready)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  //////////////////////////////////////////////////
  // checking helpers
  //////////////////////////////////////////////////

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s (got %0d, expected %0d)", $time, msg, got, exp);
      $display("Result: FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("%0t ns: %s", $time, why);
    $display("Result: FAILED");
    $fatal(1, "run aborted");
  endtask

  // zero padding outside the frame
  function automatic int pix_at(input int r, input int c);
    if (r < 0 || r >= ROWS || c < 0 || c >= COLS) begin
      return 0;
    end
    return int'(img[r * COLS + c]);
  endfunction

  task automatic model_frame(input int thr);
    int gx;
    int gy;
    int mag;
    model_edges = 0;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        gx = pix_at(r - 1, c + 1) + 2 * pix_at(r, c + 1) + pix_at(r + 1, c + 1)
           - pix_at(r - 1, c - 1) - 2 * pix_at(r, c - 1) - pix_at(r + 1, c - 1);
        gy = pix_at(r + 1, c - 1) + 2 * pix_at(r + 1, c) + pix_at(r + 1, c + 1)
           - pix_at(r - 1, c - 1) - 2 * pix_at(r - 1, c) - pix_at(r - 1, c + 1);
        mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
        if (mag > 255) begin
          mag = 255;
        end
        exp_mag_q.push_back(mag);
        exp_edge_q.push_back(mag >= thr ? 1 : 0);
        if (mag >= thr) begin
          model_edges++;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic apb_write(input addr_t addr, input data_t data);
    @(negedge clk);
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = 1'b1;
    i_paddr   = addr;
    i_pwdata  = data;
    @(negedge clk);
    i_penable = 1'b1;
    @(negedge clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  task automatic apb_read(input addr_t addr, output data_t data);
    @(negedge clk);
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
    i_paddr   = addr;
    @(negedge clk);
    i_penable = 1'b1;
    data = o_prdata;
    check(o_pready, 1, "pready in access phase");
    @(negedge clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
  endtask

  task automatic fill_random(input int max_val);
    for (int i = 0; i < NPIX; i++) begin
      img[i] = pix_t'($urandom_range(0, max_val));
    end
  endtask

  task automatic fill_const(input int val);
    for (int i = 0; i < NPIX; i++) begin
      img[i] = pix_t'(val);
    end
  endtask

  task automatic fill_checker();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        img[r * COLS + c] = ((r + c) % 2 == 1) ? 8'd255 : 8'd0;
      end
    end
  endtask

  // o_pix_ready depends on the controller state only, so it is stable here
  task automatic send_frame();
    int idx;
    idx = 0;
    while (idx < NPIX) begin
      @(negedge clk);
      if ($urandom_range(0, 3) != 0) begin
        i_pix_valid = 1'b1;
        i_pix       = img[idx];
        if (o_pix_ready) begin
          idx++;
        end
      end else begin
        i_pix_valid = 1'b0;
        i_pix       = pix_t'($urandom);
      end
    end
    @(negedge clk);
    i_pix_valid = 1'b0;
  endtask

  task automatic wait_results(input int target);
    int cycles;
    cycles = 0;
    while (res_total < target) begin
      @(negedge clk);
      cycles++;
      if (cycles > STEP_CYCLES) begin
        abort_run("timed out waiting for the results of a frame");
      end
    end
  endtask

  // the frame counter moves one cycle after the last result
  task automatic wait_frame_count(input int target);
    int polls;
    polls = 0;
    apb_read(REG_FRAMES, rd_data);
    while (rd_data < target) begin
      polls++;
      if (polls > STEP_CYCLES) begin
        abort_run("timed out waiting for the frame counter to advance");
      end
      apb_read(REG_FRAMES, rd_data);
    end
  endtask

  task automatic run_frame();
    model_frame(thresh_now);
    send_frame();
    frames_sent++;
    frames_exp++;
    wait_results(frames_sent * NPIX);
    wait_frame_count(frames_exp);
    check(rd_data, frames_exp, "REG_FRAMES after frame");
    apb_read(REG_EDGES, rd_data);
    check(rd_data, model_edges, "REG_EDGES after frame");
  endtask

  //////////////////////////////////////////////////
  // result monitor
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n && o_res_valid) begin
      if (exp_mag_q.size() == 0) begin
        abort_run("a result arrived with no pixel pending in the reference model");
      end else begin
        exp_m = exp_mag_q.pop_front();
        exp_e = exp_edge_q.pop_front();
        check(o_res.mag, exp_m, "result magnitude");
        check(o_res.edge_flag, exp_e, "result edge flag");
        got_mag[res_idx] = int'(o_res.mag);
        res_idx   = (res_idx + 1) % NPIX;
        res_total = res_total + 1;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("watchdog expired before the tests finished");
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int sat;
    void'($urandom(7699));
    rst_n       = 1'b0;
    i_pix_valid = 1'b0;
    i_pix       = '0;
    i_psel      = 1'b0;
    i_penable   = 1'b0;
    i_pwrite    = 1'b0;
    i_paddr     = '0;
    i_pwdata    = '0;
    res_idx     = 0;
    res_total   = 0;
    frames_sent = 0;
    frames_exp  = 0;
    thresh_now  = 128;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    @(negedge clk);
    check(o_pix_ready, 1, "pix ready after reset");
    check(o_res_valid, 0, "res valid after reset");
    apb_read(REG_THRESH, rd_data);
    check(rd_data, 128, "REG_THRESH reset value");
    apb_read(REG_EDGES, rd_data);
    check(rd_data, 0, "REG_EDGES reset value");
    apb_read(REG_FRAMES, rd_data);
    check(rd_data, 0, "REG_FRAMES reset value");

    for (int f = 0; f < 3; f++) begin
      fill_random(255);
      run_frame();
    end

    // flat frame, only the zero padding makes edges
    fill_const(255);
    run_frame();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        if (r == 0 || r == ROWS - 1 || c == 0 || c == COLS - 1) begin
          check(got_mag[r * COLS + c] != 0, 1, "border magnitude nonzero");
        end else begin
          check(got_mag[r * COLS + c], 0, "interior magnitude of flat frame");
        end
      end
    end

    fill_checker();
    run_frame();
    sat = 0;
    for (int i = 0; i < NPIX; i++) begin
      if (got_mag[i] == 255) begin
        sat++;
      end
    end
    check(sat > 0, 1, "checkerboard reaches saturation");

    apb_write(REG_THRESH, 32'd200);
    apb_read(REG_THRESH, rd_data);
    check(rd_data, 200, "REG_THRESH readback");
    thresh_now = 200;
    // low contrast keeps magnitudes around the threshold
    fill_random(63);
    run_frame();

    apb_write(REG_FRAMES, 32'h0000_00a5);
    frames_exp = 0;
    apb_read(REG_FRAMES, rd_data);
    check(rd_data, 0, "REG_FRAMES after clear");

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- verilog/sobel_top.sv
`timescale 1ns/10ps

module sobel_top #(
  parameter int ROWS = 5,
  parameter int COLS = 5
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                i_pix_valid,
  input  sobel_pkg::pix_t     i_pix,
  output logic                o_pix_ready,
  output logic                o_res_valid,
  output sobel_pkg::result_t  o_res,
  input  logic                i_psel,
  input  logic                i_penable,
  input  logic                i_pwrite,
  input  sobel_pkg::addr_t    i_paddr,
  input  sobel_pkg::data_t    i_pwdata,
  output sobel_pkg::data_t    o_prdata,
  output logic                o_pready
);
  import sobel_pkg::*;

  localparam int IDX_W = $clog2(COLS + 1);

  logic             buf_we;
  logic [IDX_W-1:0] col_idx;
  col_t             buf_col;
  logic             load_en;
  logic             out_en;
  logic             restart;
  window_t          win;
  logic             win_valid;
  logic             frame_end;
  grad_t            gx;
  grad_t            gy;
  logic             grad_valid;
  pix_t             thresh;
  cnt_t             edges;
  logic             frame_done;

  //////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////

  window_ctrl #(
    .ROWS (ROWS),
    .COLS (COLS)
  ) window_ctrl_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_pix_valid (i_pix_valid),
    .i_frame_end (frame_end),
    .o_pix_ready (o_pix_ready),
    .o_buf_we    (buf_we),
    .o_col_idx   (col_idx),
    .o_load_en   (load_en),
    .o_out_en    (out_en),
    .o_restart   (restart)
  );

  line_buffer #(
    .COLS (COLS)
  ) line_buffer_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_we      (buf_we),
    .i_pix     (i_pix),
    .i_col_idx (col_idx),
    .o_col     (buf_col)
  );

  window_datapath #(
    .ROWS (ROWS),
    .COLS (COLS)
  ) window_datapath_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_col       (buf_col),
    .i_load_en   (load_en),
    .i_out_en    (out_en),
    .i_restart   (restart),
    .o_win       (win),
    .o_win_valid (win_valid),
    .o_frame_end (frame_end)
  );

  //////////////////////////////////////////////////
  // gradients and result
  //////////////////////////////////////////////////

  gradient_x gradient_x_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_win   (win),
    .i_valid (win_valid),
    .o_grad  (gx),
    .o_valid (grad_valid)
  );

  // same latency as gradient_x, its valid carries both
  gradient_y gradient_y_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_win   (win),
    .i_valid (win_valid),
    .o_grad  (gy),
    .o_valid ()
  );

  edge_combine edge_combine_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_gx         (gx),
    .i_gy         (gy),
    .i_valid      (grad_valid),
    .i_frame_end  (frame_end),
    .i_thresh     (thresh),
    .o_res        (o_res),
    .o_res_valid  (o_res_valid),
    .o_edges      (edges),
    .o_frame_done (frame_done)
  );

  apb_regs apb_regs_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_paddr      (i_paddr),
    .i_pwdata     (i_pwdata),
    .i_edges      (edges),
    .i_frame_done (frame_done),
    .o_prdata     (o_prdata),
    .o_pready     (o_pready),
    .o_thresh     (thresh)
  );

endmodule

//--- verilog/apb_regs.sv
`timescale 1ns/10ps

module apb_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                i_psel,
  input  logic                i_penable,
  input  logic                i_pwrite,
  input  sobel_pkg::addr_t    i_paddr,
  input  sobel_pkg::data_t    i_pwdata,
  input  sobel_pkg::cnt_t     i_edges,
  input  logic                i_frame_done,
  output sobel_pkg::data_t    o_prdata,
  output logic                o_pready,
  output sobel_pkg::pix_t     o_thresh
);
  import sobel_pkg::*;

  logic wr_en;
  pix_t thresh_q;
  cnt_t frames_q;

  // no wait states
  assign o_pready = 1'b1;
  assign wr_en    = i_psel && i_penable && i_pwrite;
  assign o_thresh = thresh_q;

  //////////////////////////////////////////////////
  // writable state
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      thresh_q <= THRESH_RST;
    end else if (wr_en && (i_paddr == REG_THRESH)) begin
      thresh_q <= i_pwdata[PIX_W-1:0];
    end
  end

  // any write clears, a write in the same cycle as frame done wins
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      frames_q <= '0;
    end else if (wr_en && (i_paddr == REG_FRAMES)) begin
      frames_q <= '0;
    end else if (i_frame_done) begin
      frames_q <= frames_q + 1'b1;
    end
  end

  always_comb begin
    case (i_paddr)
      REG_THRESH: o_prdata = data_t'(thresh_q);
      REG_EDGES:  o_prdata = data_t'(i_edges);
      REG_FRAMES: o_prdata = data_t'(frames_q);
      default:    o_prdata = '0;
    endcase
  end

endmodule

//--- verilog/edge_combine.sv
`timescale 1ns/10ps

module edge_combine (
  input  logic                clk,
  input  logic                rst_n,
  input  sobel_pkg::grad_t    i_gx,
  input  sobel_pkg::grad_t    i_gy,
  input  logic                i_valid,
  input  logic                i_frame_end,
  input  sobel_pkg::pix_t     i_thresh,
  output sobel_pkg::result_t  o_res,
  output logic                o_res_valid,
  output sobel_pkg::cnt_t     o_edges,
  output logic                o_frame_done
);
  import sobel_pkg::*;

  grad_t abs_x;
  grad_t abs_y;
  logic [GRAD_W-1:0] sum;
  pix_t mag;
  logic is_edge;
  logic end_q;
  cnt_t edge_cnt;

  assign abs_x   = i_gx[GRAD_W-1] ? -i_gx : i_gx;
  assign abs_y   = i_gy[GRAD_W-1] ? -i_gy : i_gy;
  // at most 2040, still fits unsigned in GRAD_W bits
  assign sum     = abs_x + abs_y;
  assign mag     = (sum > GRAD_W'(255)) ? '1 : sum[PIX_W-1:0];
  assign is_edge = (mag >= i_thresh);

  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_res.mag       <= mag;
      o_res.edge_flag <= is_edge;
    end
  end

  // frame end comes with the window, one stage ahead of the gradients
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_res_valid  <= 1'b0;
      o_frame_done <= 1'b0;
      end_q        <= 1'b0;
      edge_cnt     <= '0;
      o_edges      <= '0;
    end else begin
      o_res_valid  <= i_valid;
      o_frame_done <= i_valid && end_q;
      end_q        <= i_frame_end;
      if (i_valid && end_q) begin
        o_edges  <= edge_cnt + cnt_t'(is_edge);
        edge_cnt <= '0;
      end else if (i_valid) begin
        edge_cnt <= edge_cnt + cnt_t'(is_edge);
      end
    end
  end

endmodule

//--- verilog/gradient_y.sv
`timescale 1ns/10ps

module gradient_y (
  input  logic                clk,
  input  logic                rst_n,
  input  sobel_pkg::window_t  i_win,
  input  logic                i_valid,
  output sobel_pkg::grad_t    o_grad,
  output logic                o_valid
);
  import sobel_pkg::*;

  // each weighted row is at most 4 * 255
  logic [9:0] bot_sum;
  logic [9:0] top_sum;

  assign bot_sum = 10'(i_win.p6) + 10'({i_win.p7, 1'b0}) + 10'(i_win.p8);
  assign top_sum = 10'(i_win.p0) + 10'({i_win.p1, 1'b0}) + 10'(i_win.p2);

  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_grad <= grad_t'({1'b0, bot_sum}) - grad_t'({1'b0, top_sum});
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

endmodule

//--- verilog/gradient_x.sv
`timescale 1ns/10ps

module gradient_x (
  input  logic                clk,
  input  logic                rst_n,
  input  sobel_pkg::window_t  i_win,
  input  logic                i_valid,
  output sobel_pkg::grad_t    o_grad,
  output logic                o_valid
);
  import sobel_pkg::*;

  // each weighted column is at most 4 * 255
  logic [9:0] right_sum;
  logic [9:0] left_sum;

  assign right_sum = 10'(i_win.p2) + 10'({i_win.p5, 1'b0}) + 10'(i_win.p8);
  assign left_sum  = 10'(i_win.p0) + 10'({i_win.p3, 1'b0}) + 10'(i_win.p6);

  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_grad <= grad_t'({1'b0, right_sum}) - grad_t'({1'b0, left_sum});
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

endmodule

//--- verilog/window_ctrl.sv
`timescale 1ns/10ps

module window_ctrl #(
  parameter int ROWS = 5,
  parameter int COLS = 5
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        i_pix_valid,
  input  logic                        i_frame_end,
  output logic                        o_pix_ready,
  output logic                        o_buf_we,
  output logic [$clog2(COLS+1)-1:0]   o_col_idx,
  output logic                        o_load_en,
  output logic                        o_out_en,
  output logic                        o_restart
);
  import sobel_pkg::*;

  localparam int RW = $clog2(ROWS);
  localparam int CW = $clog2(COLS + 1);
  localparam logic [RW-1:0] LAST_ROW  = RW'(ROWS - 1);
  localparam logic [CW-1:0] LAST_COL  = CW'(COLS - 1);
  localparam logic [CW-1:0] FLUSH_END = CW'(COLS);

  ctrl_state_t state_q, state_d;
  logic [RW-1:0] row_q, row_d;
  logic [CW-1:0] col_q, col_d;
  logic take;

  assign o_pix_ready = (state_q == IDLE) || (state_q == ACCEPT) || (state_q == DONE);
  assign take        = o_pix_ready && i_pix_valid;
  assign o_col_idx   = col_q;
  assign o_restart   = (state_q == DONE) && i_frame_end;

  always_comb begin
    state_d   = state_q;
    row_d     = row_q;
    col_d     = col_q;
    o_buf_we  = 1'b0;
    o_load_en = 1'b0;
    o_out_en  = 1'b0;
    case (state_q)
      IDLE, ACCEPT, DONE: begin
        if (take) begin
          o_buf_we  = 1'b1;
          o_load_en = 1'b1;
          // row 0 and column 0 only fill the window
          o_out_en  = (row_q != '0) && (col_q != '0);
          if (col_q != LAST_COL) begin
            col_d   = col_q + 1'b1;
            state_d = ACCEPT;
          end else if (row_q == '0) begin
            row_d   = row_q + 1'b1;
            col_d   = '0;
            state_d = ACCEPT;
          end else begin
            state_d = FLUSH_COL;
          end
        end else if (state_q == DONE) begin
          state_d = IDLE;
        end
      end
      FLUSH_COL: begin
        o_load_en = 1'b1;
        o_out_en  = 1'b1;
        col_d     = '0;
        if (row_q == LAST_ROW) begin
          state_d = FLUSH_ROW;
        end else begin
          row_d   = row_q + 1'b1;
          state_d = ACCEPT;
        end
      end
      FLUSH_ROW: begin
        // COLS+1 steps, the last one is the flush column of the flush row
        o_load_en = 1'b1;
        o_out_en  = (col_q != '0);
        if (col_q == FLUSH_END) begin
          row_d   = '0;
          col_d   = '0;
          state_d = DONE;
        end else begin
          col_d = col_q + 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
      row_q   <= '0;
      col_q   <= '0;
    end else begin
      state_q <= state_d;
      row_q   <= row_d;
      col_q   <= col_d;
    end
  end

endmodule

//--- verilog/window_datapath.sv
`timescale 1ns/10ps

module window_datapath #(
  parameter int ROWS = 5,
  parameter int COLS = 5
) (
  input  logic                clk,
  input  logic                rst_n,
  input  sobel_pkg::col_t     i_col,
  input  logic                i_load_en,
  input  logic                i_out_en,
  input  logic                i_restart,
  output sobel_pkg::window_t  o_win,
  output logic                o_win_valid,
  output logic                o_frame_end
);
  import sobel_pkg::*;

  // row counter runs up to ROWS after the last window until restart
  localparam int RW = $clog2(ROWS + 1);
  localparam int CW = $clog2(COLS);
  localparam logic [RW-1:0] LAST_ROW = RW'(ROWS - 1);
  localparam logic [CW-1:0] LAST_COL = CW'(COLS - 1);

  col_t col_a;
  col_t col_b;
  logic [RW-1:0] row_q;
  logic [CW-1:0] col_q;
  logic at_top;
  logic at_bottom;
  logic at_left;
  logic at_right;

  // centre of the window produced on the next output step
  assign at_top    = (row_q == '0);
  assign at_bottom = (row_q == LAST_ROW);
  assign at_left   = (col_q == '0);
  assign at_right  = (col_q == LAST_COL);

  //////////////////////////////////////////////////
  // centre counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n || i_restart) begin
      col_q <= '0;
    end else if (i_out_en) begin
      col_q <= at_right ? '0 : col_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || i_restart) begin
      row_q <= '0;
    end else if (i_out_en && at_right) begin
      row_q <= row_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // column shift and window register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_load_en) begin
      col_a <= col_b;
      col_b <= i_col;
    end
  end

  // incoming column is the right one, col_b the centre
  always_ff @(posedge clk) begin
    if (i_out_en) begin
      o_win.p0 <= (at_top || at_left) ? '0 : col_a.top;
      o_win.p1 <= at_top ? '0 : col_b.top;
      o_win.p2 <= (at_top || at_right) ? '0 : i_col.top;
      o_win.p3 <= at_left ? '0 : col_a.mid;
      o_win.p4 <= col_b.mid;
      o_win.p5 <= at_right ? '0 : i_col.mid;
      o_win.p6 <= (at_bottom || at_left) ? '0 : col_a.bot;
      o_win.p7 <= at_bottom ? '0 : col_b.bot;
      o_win.p8 <= (at_bottom || at_right) ? '0 : i_col.bot;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_win_valid <= 1'b0;
      o_frame_end <= 1'b0;
    end else begin
      o_win_valid <= i_out_en;
      o_frame_end <= i_out_en && at_bottom && at_right;
    end
  end

endmodule

//--- verilog/line_buffer.sv
`timescale 1ns/10ps

module line_buffer #(
  parameter int COLS = 5
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        i_we,
  input  sobel_pkg::pix_t             i_pix,
  input  logic [$clog2(COLS+1)-1:0]   i_col_idx,
  output sobel_pkg::col_t             o_col
);
  import sobel_pkg::*;

  // row_top holds the row two above the incoming one, row_mid the row just above
  pix_t row_top [COLS];
  pix_t row_mid [COLS];

  assign o_col.top = row_top[i_col_idx];
  assign o_col.mid = row_mid[i_col_idx];
  assign o_col.bot = i_pix;

  //////////////////////////////////////////////////
  // column shift on write
  //////////////////////////////////////////////////

  // no writes land while the pipeline is held in reset
  always_ff @(posedge clk) begin
    if (rst_n && i_we) begin
      row_top[i_col_idx] <= row_mid[i_col_idx];
      row_mid[i_col_idx] <= i_pix;
    end
  end

endmodule

//--- verilog/sobel_pkg.sv
package sobel_pkg;

  localparam int PIX_W  = 8;
  localparam int GRAD_W = 11;
  localparam int CNT_W  = 16;
  localparam int ADDR_W = 4;
  localparam int DATA_W = 32;

  typedef logic [PIX_W-1:0]         pix_t;
  typedef logic signed [GRAD_W-1:0] grad_t;
  typedef logic [CNT_W-1:0]         cnt_t;
  typedef logic [ADDR_W-1:0]        addr_t;
  typedef logic [DATA_W-1:0]        data_t;

  // one column of the window, top row first
  typedef struct packed {
    pix_t top;
    pix_t mid;
    pix_t bot;
  } col_t;

  // p0..p2 top row, p3..p5 middle, p6..p8 bottom, left to right
  typedef struct packed {
    pix_t p0;
    pix_t p1;
    pix_t p2;
    pix_t p3;
    pix_t p4;
    pix_t p5;
    pix_t p6;
    pix_t p7;
    pix_t p8;
  } window_t;

  // one output pixel, magnitude and edge flag
  typedef struct packed {
    pix_t mag;
    logic edge_flag;
  } result_t;

  typedef enum logic [2:0] {
    IDLE,
    ACCEPT,
    FLUSH_COL,
    FLUSH_ROW,
    DONE
  } ctrl_state_t;

  // register map
  localparam addr_t REG_THRESH = 4'h0;
  localparam addr_t REG_EDGES  = 4'h4;
  localparam addr_t REG_FRAMES = 4'h8;

  localparam pix_t THRESH_RST = 8'd128;

endpackage
